//--- list.f
+incdir+logic
logic/surf_bus_pkg.sv
logic/surf_board_pkg.sv
logic/wbc_intercon.sv
logic/surf_id_ctrl.sv
logic/timing_monitor.sv
logic/surf_top.sv
sim/surf_tb.sv

//--- sim/surf_tb.sv
`include "surf_defs.svh"

module surf_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_ctrl = 12;
	localparam int n_mon = 4;
	localparam int n_drive = 5;
	localparam int n_flag = 6;
	// All bus accesses of the run, per test in order.
	localparam int n_access = 3 + 2 * n_ctrl + 2 + 3 + 4 + 1 + 4 * n_mon + 2 * n_flag;
	// 200 clocks of 4 ns per access, plus some slack.
	localparam int wd_ns = n_access * 200 * 4 + 1000;

	// Version word as the board should report it.
	localparam surf_board_pkg::version_t version_exp = '{
		boardrev: `SURF_BOARDREV,
		month: `SURF_MONTH,
		day: `SURF_DAY,
		major: `SURF_MAJOR,
		minor: `SURF_MINOR,
		revision: `SURF_REVISION
	};

	logic sys_clk = 1'b0;
	logic arst_n_i;
	// Index 0 is the PCI bridge, 1 the trigger link, 2 the debug bridge.
	surf_bus_pkg::wb_req_t m_req [`SURF_NUM_MASTERS];
	surf_bus_pkg::wb_rsp_t m_rsp [`SURF_NUM_MASTERS];
	logic [`SURF_MON_CH-1:0] montiming_i;
	logic div4_flag_i;
	logic clk_sel_o;
	logic local_osc_en_o;
	logic [3:0] led_o;
	logic [`SURF_MON_CH-1:0] montiming_o;
	logic sst_copy_o;
	surf_board_pkg::bus_capture_t debug_o;

	// Expected responses per master.
	logic chk_rd [`SURF_NUM_MASTERS];
	logic exp_err [`SURF_NUM_MASTERS];
	logic [`SURF_DATA_W-1:0] exp_rd [`SURF_NUM_MASTERS];
	logic [`SURF_DATA_W-1:0] ctrl_exp;
	logic [`SURF_DATA_W-1:0] scratch_exp;
	logic [`SURF_MON_CH-1:0] seen_exp;
	logic [`SURF_MON_CH-1:0] mon_exp;
	surf_board_pkg::bus_capture_t cap_now;
	surf_board_pkg::bus_capture_t cap_half;
	surf_board_pkg::bus_capture_t cap_exp;
	logic ctrl_chk;
	logic mon_chk;
	logic solo;
	logic arb_on;
	int done_cnt;
	int errors = 0;
	int seed = 32'h3dc1;

	always #2 sys_clk = ~sys_clk;

	surf_top uut (
		.sys_clk(sys_clk),
		.arst_n_i(arst_n_i),
		.pcic_req_i(m_req[0]),
		.turfc_req_i(m_req[1]),
		.wbvio_req_i(m_req[2]),
		.pcic_rsp_o(m_rsp[0]),
		.turfc_rsp_o(m_rsp[1]),
		.wbvio_rsp_o(m_rsp[2]),
		.montiming_i(montiming_i),
		.div4_flag_i(div4_flag_i),
		.clk_sel_o(clk_sel_o),
		.local_osc_en_o(local_osc_en_o),
		.led_o(led_o),
		.montiming_o(montiming_o),
		.sst_copy_o(sst_copy_o),
		.debug_o(debug_o)
	);

	// Write data on writes, returned data otherwise.
	always_comb begin
		cap_now = '0;
		cap_now.dat = m_req[0].we ? m_req[0].dat : m_rsp[0].dat;
		cap_now.adr = m_req[0].adr.flat;
		cap_now.sel = m_req[0].sel;
		cap_now.cyc = m_req[0].cyc;
		cap_now.stb = m_req[0].stb;
		cap_now.we = m_req[0].we;
		cap_now.ack = m_rsp[0].ack;
		cap_now.err = m_rsp[0].err;
	end

	// Take the PCI port mid-cycle, hand it on at the edge.
	always @(negedge sys_clk) begin
		cap_half <= cap_now;
	end

	always @(posedge sys_clk) begin
		cap_exp <= cap_half;
		// Swapped pairs read inverted.
		mon_exp <= montiming_i ^ `SURF_MON_POL;
	end

	function automatic logic [`SURF_DATA_W-1:0] byte_merge(input logic [`SURF_DATA_W-1:0] old_w,
			input logic [`SURF_DATA_W-1:0] new_w, input logic [`SURF_SEL_W-1:0] sel);
		logic [`SURF_DATA_W-1:0] mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (new_w & mask) | (old_w & ~mask);
	endfunction

	function automatic logic [`SURF_ADR_W-1:0] win_adr(input logic [`SURF_WIN_W-1:0] win,
			input logic [`SURF_OFS_W-1:0] ofs);
		return {win, ofs};
	endfunction

	// One access of master m, returns once the response pulse is over.
	task automatic bus_access(input int m, input logic we, input logic [`SURF_SEL_W-1:0] sel,
			input logic [`SURF_ADR_W-1:0] adr, input logic [`SURF_DATA_W-1:0] dat,
			input logic chk, input logic [`SURF_DATA_W-1:0] exp_dat, input logic err);
		@(posedge sys_clk);
		#0.5;
		chk_rd[m] = chk;
		exp_rd[m] = exp_dat;
		exp_err[m] = err;
		m_req[m].we = we;
		m_req[m].sel = sel;
		m_req[m].adr.flat = adr;
		m_req[m].dat = dat;
		m_req[m].cyc = 1'b1;
		m_req[m].stb = 1'b1;
		// Held until ack or err shows up.
		do begin
			@(negedge sys_clk);
		end while (!(m_rsp[m].ack || m_rsp[m].err));
		@(posedge sys_clk);
		#0.5;
		m_req[m] = '0;
		done_cnt++;
	endtask

	for (genvar m = 0; m < `SURF_NUM_MASTERS; m++) begin : g_master
		a_rd_dat: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
			m_rsp[m].ack && chk_rd[m] |-> m_rsp[m].dat === exp_rd[m])
		else begin
			errors++;
			$display("** Error: m_rsp[%0d].dat = %h, expected %h", m,
				$sampled(m_rsp[m].dat), $sampled(exp_rd[m]));
		end
		// Unmapped windows end in err, mapped ones in ack.
		a_err: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
			m_rsp[m].ack || m_rsp[m].err |-> m_rsp[m].err === exp_err[m])
		else begin
			errors++;
			$display("** Error: m_rsp[%0d].err = %h, expected %h", m,
				$sampled(m_rsp[m].err), $sampled(exp_err[m]));
		end
		a_own_stb: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
			m_rsp[m].ack || m_rsp[m].err |-> m_req[m].cyc && m_req[m].stb)
		else begin
			errors++;
			$display("Master %0d got a response it did not ask for", m);
		end
		// PCI first, then trigger link, then debug.
		a_order: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
			arb_on && m_rsp[m].ack |-> done_cnt == m)
		else begin
			errors++;
			$display("Master %0d was answered out of priority order", m);
		end
		a_latency: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
			solo && $rose(m_req[m].stb) |-> ##2 (m_rsp[m].ack || m_rsp[m].err))
		else begin
			errors++;
			$display("Master %0d was not answered two cycles after its strobe", m);
		end
	end

	a_ctrl_out: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		ctrl_chk |-> clk_sel_o === ctrl_exp[0] && local_osc_en_o === !ctrl_exp[1]
			&& led_o === ctrl_exp[5:2])
	else begin
		errors++;
		$display("** Error: clk_sel_o/local_osc_en_o/led_o = %h/%h/%h, expected %h/%h/%h",
			$sampled(clk_sel_o), $sampled(local_osc_en_o), $sampled(led_o),
			$sampled(ctrl_exp[0]), $sampled(!ctrl_exp[1]), $sampled(ctrl_exp[5:2]));
	end

	a_mon_out: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		mon_chk |-> montiming_o === mon_exp)
	else begin
		errors++;
		$display("** Error: montiming_o = %h, expected %h", $sampled(montiming_o),
			$sampled(mon_exp));
	end

	a_sst: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		$rose(div4_flag_i) |-> !sst_copy_o ##1 sst_copy_o ##1 sst_copy_o ##1 !sst_copy_o)
	else begin
		errors++;
		$display("sst_copy_o was not high for exactly two cycles after a flag");
	end

	a_capture: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		cap_exp.cyc |-> debug_o === cap_exp)
	else begin
		errors++;
		$display("** Error: debug_o = %h, expected %h", $sampled(debug_o), $sampled(cap_exp));
	end

	initial begin
		logic [`SURF_DATA_W-1:0] wd;
		logic [`SURF_SEL_W-1:0] sel;
		logic [`SURF_MON_CH-1:0] corr;
		logic [`SURF_MON_CH-1:0] clr;
		arst_n_i = 1'b0;
		for (int m = 0; m < `SURF_NUM_MASTERS; m++) begin
			m_req[m] = '0;
			chk_rd[m] = 1'b0;
			exp_err[m] = 1'b0;
			exp_rd[m] = '0;
		end
		montiming_i = '0;
		div4_flag_i = 1'b0;
		ctrl_exp = '0;
		ctrl_chk = 1'b1;
		mon_chk = 1'b0;
		solo = 1'b1;
		arb_on = 1'b0;
		done_cnt = 0;
		repeat (8) @(posedge sys_clk);
		#0.5;
		arst_n_i = 1'b1;
		repeat (2) @(posedge sys_clk);
		#0.5;
		mon_chk = 1'b1;
		// Version word from every master.
		for (int m = 0; m < `SURF_NUM_MASTERS; m++)
			bus_access(m, 1'b0, 4'hf, win_adr(`SURF_WIN_ID, 16'd0), '0, 1'b1, version_exp, 1'b0);
		// Control register under byte selects.
		for (int i = 0; i < n_ctrl; i++) begin
			wd = $random(seed);
			sel = $random(seed);
			if (i % 3 == 0)
				sel = 4'hf;
			ctrl_chk = 1'b0;
			bus_access(i % 3, 1'b1, sel, win_adr(`SURF_WIN_ID, 16'd1), wd, 1'b0, '0, 1'b0);
			ctrl_exp = byte_merge(ctrl_exp, wd, sel);
			ctrl_chk = 1'b1;
			bus_access(i % 3, 1'b0, 4'hf, win_adr(`SURF_WIN_ID, 16'd1), '0, 1'b1, ctrl_exp, 1'b0);
		end
		scratch_exp = $random(seed);
		bus_access(1, 1'b1, 4'hf, win_adr(`SURF_WIN_ID, 16'd2), scratch_exp, 1'b0, '0, 1'b0);
		bus_access(2, 1'b0, 4'hf, win_adr(`SURF_WIN_ID, 16'd2), '0, 1'b1, scratch_exp, 1'b0);
		// Three masters in the same cycle.
		solo = 1'b0;
		arb_on = 1'b1;
		done_cnt = 0;
		fork
			bus_access(0, 1'b0, 4'hf, win_adr(`SURF_WIN_ID, 16'd0), '0, 1'b1, version_exp, 1'b0);
			bus_access(1, 1'b0, 4'hf, win_adr(`SURF_WIN_ID, 16'd2), '0, 1'b1, scratch_exp, 1'b0);
			bus_access(2, 1'b0, 4'hf, win_adr(`SURF_WIN_ID, 16'd1), '0, 1'b1, ctrl_exp, 1'b0);
		join
		arb_on = 1'b0;
		solo = 1'b1;
		// LAB4 RAM and RF power have nothing behind them.
		bus_access(0, 1'b0, 4'hf, win_adr(`SURF_WIN_L4RAM, 16'h0010), '0, 1'b0, '0, 1'b1);
		bus_access(1, 1'b1, 4'h3, win_adr(`SURF_WIN_L4RAM, 16'hff00), $random(seed), 1'b0, '0, 1'b1);
		bus_access(2, 1'b0, 4'hf, win_adr(`SURF_WIN_RFP, 16'h0001), '0, 1'b0, '0, 1'b1);
		bus_access(0, 1'b1, 4'hf, win_adr(`SURF_WIN_RFP, 16'h0042), $random(seed), 1'b0, '0, 1'b1);
		// Timing monitor, start from an empty seen mask.
		bus_access(2, 1'b1, 4'hf, win_adr(`SURF_WIN_L4CTRL, 16'd1), 32'hfff, 1'b0, '0, 1'b0);
		seen_exp = montiming_i ^ `SURF_MON_POL;
		for (int r = 0; r < n_mon; r++) begin
			repeat (n_drive) begin
				@(posedge sys_clk);
				#0.5;
				montiming_i = $random(seed);
				seen_exp = seen_exp | (montiming_i ^ `SURF_MON_POL);
			end
			corr = montiming_i ^ `SURF_MON_POL;
			bus_access(r % 3, 1'b0, 4'hf, win_adr(`SURF_WIN_L4CTRL, 16'd0), '0, 1'b1,
				{20'h0, corr}, 1'b0);
			bus_access(r % 3, 1'b0, 4'hf, win_adr(`SURF_WIN_L4CTRL, 16'd1), '0, 1'b1,
				{20'h0, seen_exp}, 1'b0);
			clr = $random(seed);
			bus_access(2, 1'b1, 4'hf, win_adr(`SURF_WIN_L4CTRL, 16'd1), {20'h0, clr}, 1'b0, '0, 1'b0);
			// Live bits come straight back after the clear.
			seen_exp = (seen_exp & ~clr) | corr;
			bus_access(1, 1'b0, 4'hf, win_adr(`SURF_WIN_L4CTRL, 16'd1), '0, 1'b1,
				{20'h0, seen_exp}, 1'b0);
		end
		// Isolated flags while the PCI port runs scratch traffic.
		fork
			for (int i = 0; i < n_flag; i++) begin
				@(posedge sys_clk);
				#0.5;
				div4_flag_i = 1'b1;
				@(posedge sys_clk);
				#0.5;
				div4_flag_i = 1'b0;
				repeat (4 + i % 3) @(posedge sys_clk);
			end
			for (int i = 0; i < n_flag; i++) begin
				wd = $random(seed);
				sel = $random(seed);
				bus_access(0, 1'b1, sel, win_adr(`SURF_WIN_ID, 16'd2), wd, 1'b0, '0, 1'b0);
				scratch_exp = byte_merge(scratch_exp, wd, sel);
				bus_access(0, 1'b0, 4'hf, win_adr(`SURF_WIN_ID, 16'd2), '0, 1'b1, scratch_exp, 1'b0);
			end
		join
		repeat (4) @(posedge sys_clk);
		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Watchdog.
	initial begin
		#(wd_ns);
		$display("Watchdog expired at %0t, a bus access never finished", $time);
		$display("Run finished with %0d errors", errors);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- logic/surf_top.sv
`include "surf_defs.svh"

module surf_top (
	input logic sys_clk,
	input logic arst_n_i,
	// PCI bridge, trigger-board link, debug bridge.
	input surf_bus_pkg::wb_req_t pcic_req_i,
	input surf_bus_pkg::wb_req_t turfc_req_i,
	input surf_bus_pkg::wb_req_t wbvio_req_i,
	output surf_bus_pkg::wb_rsp_t pcic_rsp_o,
	output surf_bus_pkg::wb_rsp_t turfc_rsp_o,
	output surf_bus_pkg::wb_rsp_t wbvio_rsp_o,
	input logic [`SURF_MON_CH-1:0] montiming_i,
	input logic div4_flag_i,
	output logic clk_sel_o,
	output logic local_osc_en_o,
	output logic [3:0] led_o,
	output logic [`SURF_MON_CH-1:0] montiming_o,
	output logic sst_copy_o,
	output surf_board_pkg::bus_capture_t debug_o
);

	surf_bus_pkg::wb_req_t m_req [`SURF_NUM_MASTERS];
	surf_bus_pkg::wb_rsp_t m_rsp [`SURF_NUM_MASTERS];
	surf_bus_pkg::wb_req_t id_req;
	surf_bus_pkg::wb_rsp_t id_rsp;
	surf_bus_pkg::wb_req_t mon_req;
	surf_bus_pkg::wb_rsp_t mon_rsp;

	// Master order sets the priority, PCI first.
	assign m_req[0] = pcic_req_i;
	assign m_req[1] = turfc_req_i;
	assign m_req[2] = wbvio_req_i;
	assign pcic_rsp_o = m_rsp[0];
	assign turfc_rsp_o = m_rsp[1];
	assign wbvio_rsp_o = m_rsp[2];

	wbc_intercon u_intercon (
		.sys_clk(sys_clk),
		.arst_n_i(arst_n_i),
		.m_req_i(m_req),
		.m_rsp_o(m_rsp),
		.id_req_o(id_req),
		.id_rsp_i(id_rsp),
		.mon_req_o(mon_req),
		.mon_rsp_i(mon_rsp),
		.debug_o(debug_o)
	);

	// Window 0.
	surf_id_ctrl u_id_ctrl (
		.sys_clk(sys_clk),
		.arst_n_i(arst_n_i),
		.req_i(id_req),
		.rsp_o(id_rsp),
		.clk_sel_o(clk_sel_o),
		.local_osc_en_o(local_osc_en_o),
		.led_o(led_o)
	);

	// Window 1, where the LAB4 controller used to sit.
	timing_monitor u_timing_monitor (
		.sys_clk(sys_clk),
		.arst_n_i(arst_n_i),
		.req_i(mon_req),
		.rsp_o(mon_rsp),
		.montiming_i(montiming_i),
		.div4_flag_i(div4_flag_i),
		.montiming_o(montiming_o),
		.sst_copy_o(sst_copy_o)
	);

endmodule

//--- logic/timing_monitor.sv
`include "surf_defs.svh"

module timing_monitor (
	input logic sys_clk,
	input logic arst_n_i,
	input surf_bus_pkg::wb_req_t req_i,
	output surf_bus_pkg::wb_rsp_t rsp_o,
	input logic [`SURF_MON_CH-1:0] montiming_i,
	input logic div4_flag_i,
	output logic [`SURF_MON_CH-1:0] montiming_o,
	output logic sst_copy_o
);

	localparam logic [`SURF_OFS_W-1:0] ofs_sample = 16'd0;
	localparam logic [`SURF_OFS_W-1:0] ofs_seen = 16'd1;
	localparam int pad_w = `SURF_DATA_W - `SURF_MON_CH;

	logic hit;
	logic clr_en;
	logic ack_q;
	logic [`SURF_DATA_W-1:0] dat_q;
	logic [`SURF_MON_CH-1:0] mon_q;
	logic [`SURF_MON_CH-1:0] seen_q;
	logic [`SURF_MON_CH-1:0] clr;
	logic [1:0] div4_q;
	logic sst_q;

	assign hit = req_i.cyc & req_i.stb & ~ack_q;
	assign clr_en = hit & req_i.we & (req_i.adr.win_view.ofs == ofs_seen);
	// Write ones to clear.
	assign clr = clr_en ? req_i.dat[`SURF_MON_CH-1:0] : '0;

	// Sampler with polarity fix.
	// Swapped pairs come in inverted.
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mon_q <= '0;
			seen_q <= '0;
			ack_q <= 1'b0;
		end else begin
			mon_q <= montiming_i ^ `SURF_MON_POL;
			// Clear wins in the write cycle, a live bit sets again next cycle.
			seen_q <= (seen_q | mon_q) & ~clr;
			ack_q <= hit;
		end
	end

	always_ff @(posedge sys_clk) begin
		case (req_i.adr.win_view.ofs)
			ofs_sample: dat_q <= {{pad_w{1'b0}}, mon_q};
			ofs_seen: dat_q <= {{pad_w{1'b0}}, seen_q};
			default: dat_q <= '0;
		endcase
	end

	assign rsp_o = '{ack: ack_q, err: 1'b0, dat: dat_q};
	assign montiming_o = mon_q;

	// SST copy.
	// Set by the div-by-4 flag, cleared when the flag leaves the two-stage delay.
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			div4_q <= '0;
			sst_q <= 1'b0;
		end else begin
			div4_q <= {div4_q[0], div4_flag_i};
			if (div4_flag_i)
				sst_q <= 1'b1;
			else if (div4_q[1])
				sst_q <= 1'b0;
		end
	end

	assign sst_copy_o = sst_q;

	// With isolated flags the copy is gone three cycles after the flag.
	a_sst_width: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		div4_flag_i ##1 (!div4_flag_i) [*3] |-> !sst_q);

endmodule

//--- logic/surf_id_ctrl.sv
`include "surf_defs.svh"

module surf_id_ctrl (
	input logic sys_clk,
	input logic arst_n_i,
	input surf_bus_pkg::wb_req_t req_i,
	output surf_bus_pkg::wb_rsp_t rsp_o,
	output logic clk_sel_o,
	output logic local_osc_en_o,
	output logic [3:0] led_o
);

	// Register offsets inside the ID window.
	localparam logic [`SURF_OFS_W-1:0] ofs_version = 16'd0;
	localparam logic [`SURF_OFS_W-1:0] ofs_ctrl = 16'd1;
	localparam logic [`SURF_OFS_W-1:0] ofs_scratch = 16'd2;

	// Fixed version word.
	localparam surf_board_pkg::version_t version_c = '{
		boardrev: `SURF_BOARDREV,
		month: `SURF_MONTH,
		day: `SURF_DAY,
		major: `SURF_MAJOR,
		minor: `SURF_MINOR,
		revision: `SURF_REVISION
	};

	logic hit;
	logic wr_ctrl;
	logic wr_scratch;
	logic ack_q;
	logic [`SURF_DATA_W-1:0] dat_q;
	logic [`SURF_DATA_W-1:0] scratch_q;
	surf_board_pkg::ctrl_reg_t ctrl_q;

	// Byte-lane merge of new write data into an old word.
	function automatic logic [`SURF_DATA_W-1:0] merge_bytes(
		input logic [`SURF_DATA_W-1:0] old_w,
		input logic [`SURF_DATA_W-1:0] new_w,
		input logic [`SURF_SEL_W-1:0] sel
	);
		logic [`SURF_DATA_W-1:0] res;
		res = old_w;
		for (int b = 0; b < `SURF_SEL_W; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	// Serve a strobe once, the cycle our own ack is low.
	assign hit = req_i.cyc & req_i.stb & ~ack_q;
	assign wr_ctrl = hit & req_i.we & (req_i.adr.win_view.ofs == ofs_ctrl);
	assign wr_scratch = hit & req_i.we & (req_i.adr.win_view.ofs == ofs_scratch);

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
			ctrl_q <= '0;
		end else begin
			ack_q <= hit;
			if (wr_ctrl)
				ctrl_q <= merge_bytes(ctrl_q, req_i.dat, req_i.sel);
		end
	end

	// Scratch word and read data.
	// Read data lines up with the ack.
	always_ff @(posedge sys_clk) begin
		if (wr_scratch)
			scratch_q <= merge_bytes(scratch_q, req_i.dat, req_i.sel);
		case (req_i.adr.win_view.ofs)
			ofs_version: dat_q <= version_c;
			ofs_ctrl: dat_q <= ctrl_q;
			ofs_scratch: dat_q <= scratch_q;
			default: dat_q <= '0;
		endcase
	end

	assign rsp_o = '{ack: ack_q, err: 1'b0, dat: dat_q};

	// Board controls.
	// The oscillator enable pin is active high, the register bit is a disable.
	assign clk_sel_o = ctrl_q.clk_sel;
	assign local_osc_en_o = ~ctrl_q.osc_disable;
	assign led_o = ctrl_q.led;

	// The strobe is still held when the ack comes back.
	a_ack_after_stb: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		ack_q |-> req_i.cyc && req_i.stb);

endmodule

//--- logic/wbc_intercon.sv
`include "surf_defs.svh"

module wbc_intercon (
	input logic sys_clk,
	input logic arst_n_i,
	input surf_bus_pkg::wb_req_t m_req_i [`SURF_NUM_MASTERS],
	output surf_bus_pkg::wb_rsp_t m_rsp_o [`SURF_NUM_MASTERS],
	output surf_bus_pkg::wb_req_t id_req_o,
	input surf_bus_pkg::wb_rsp_t id_rsp_i,
	output surf_bus_pkg::wb_req_t mon_req_o,
	input surf_bus_pkg::wb_rsp_t mon_rsp_i,
	output surf_board_pkg::bus_capture_t debug_o
);

	// One bit per master, index 0 is the PCI bridge.
	logic [`SURF_NUM_MASTERS-1:0] grant_q;
	logic [`SURF_NUM_MASTERS-1:0] grant_d;
	// Request of whoever owns the bus, zero when idle.
	surf_bus_pkg::wb_req_t oreq;
	surf_bus_pkg::wb_rsp_t bus_rsp;
	logic id_sel;
	logic mon_sel;
	logic bad_sel;
	logic err_q;
	surf_board_pkg::bus_capture_t debug_q;

	// Owner mux.
	// The grant is one-hot, so an OR of the masked requests is enough.
	always_comb begin
		oreq = '0;
		for (int i = 0; i < `SURF_NUM_MASTERS; i++) begin
			if (grant_q[i])
				oreq = oreq | m_req_i[i];
		end
	end

	// Fixed priority.
	// Scan from the lowest priority up so the lowest index wins.
	always_comb begin
		grant_d = grant_q;
		if (grant_q == '0) begin
			for (int i = `SURF_NUM_MASTERS - 1; i >= 0; i--) begin
				if (m_req_i[i].cyc) begin
					grant_d = '0;
					grant_d[i] = 1'b1;
				end
			end
		end else if (!oreq.cyc) begin
			// Owner dropped cyc, bus goes idle for one cycle.
			grant_d = '0;
		end
	end

	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i)
			grant_q <= '0;
		else
			grant_q <= grant_d;
	end

	// Window decode from the top address bits.
	always_comb begin
		id_sel = 1'b0;
		mon_sel = 1'b0;
		bad_sel = 1'b0;
		case (oreq.adr.win_view.win)
			`SURF_WIN_ID: id_sel = 1'b1;
			`SURF_WIN_L4CTRL: mon_sel = 1'b1;
			// LAB4 RAM and RF power stay decoded but have nothing behind them.
			`SURF_WIN_L4RAM, `SURF_WIN_RFP: bad_sel = 1'b1;
			default: bad_sel = 1'b1;
		endcase
	end

	// Same request to both slaves, only the strobe is steered.
	always_comb begin
		id_req_o = oreq;
		id_req_o.stb = oreq.stb & id_sel;
		mon_req_o = oreq;
		mon_req_o.stb = oreq.stb & mon_sel;
	end

	// Error for unmapped windows, one cycle after the strobe.
	// A held strobe is answered only once.
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i)
			err_q <= 1'b0;
		else
			err_q <= oreq.cyc & oreq.stb & bad_sel & ~err_q;
	end

	// Response routing, no register on the way back.
	always_comb begin
		bus_rsp = '0;
		if (id_sel)
			bus_rsp = id_rsp_i;
		else if (mon_sel)
			bus_rsp = mon_rsp_i;
		bus_rsp.err = bus_rsp.err | err_q;
		for (int i = 0; i < `SURF_NUM_MASTERS; i++) begin
			// Masters without the grant see nothing and keep waiting.
			m_rsp_o[i] = grant_q[i] ? bus_rsp : '0;
		end
	end

	// PCI port capture.
	// Write data on writes, returned data on reads.
	always_ff @(posedge sys_clk) begin
		debug_q.dat <= m_req_i[0].we ? m_req_i[0].dat : m_rsp_o[0].dat;
		debug_q.adr <= m_req_i[0].adr.flat;
		debug_q.sel <= m_req_i[0].sel;
		debug_q.cyc <= m_req_i[0].cyc;
		debug_q.stb <= m_req_i[0].stb;
		debug_q.we <= m_req_i[0].we;
		debug_q.ack <= m_rsp_o[0].ack;
		debug_q.err <= m_rsp_o[0].err;
		// This bus never retries.
		debug_q.rty <= 1'b0;
	end

	assign debug_o = debug_q;

	// Never two owners at once.
	a_grant_onehot: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		$onehot0(grant_q));

	// Slave ack and decoder error must not collide.
	a_ack_err_excl: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		!(bus_rsp.ack && bus_rsp.err));

endmodule

//--- logic/surf_board_pkg.sv
`include "surf_defs.svh"

package surf_board_pkg;

	// Firmware version word as read at offset 0 of the ID window.
	// Board revision sits in the top nibble.
	typedef struct packed {
		logic [3:0] boardrev;
		logic [3:0] month;
		logic [7:0] day;
		logic [3:0] major;
		logic [3:0] minor;
		logic [7:0] revision;
	} version_t;

	// Board control register.
	// Bit 0 selects the bus clock source, bit 1 turns the local oscillator off.
	typedef struct packed {
		logic [25:0] rsvd;
		logic [3:0] led;
		logic osc_disable;
		logic clk_sel;
	} ctrl_reg_t;

	// Debug record of one master port, one per clock.
	// Data in the low 32 bits, strobes and response bits on top.
	typedef struct packed {
		logic rty;
		logic err;
		logic ack;
		logic we;
		logic stb;
		logic cyc;
		logic [`SURF_SEL_W-1:0] sel;
		logic [`SURF_ADR_W-1:0] adr;
		logic [`SURF_DATA_W-1:0] dat;
	} bus_capture_t;

endpackage

//--- logic/surf_bus_pkg.sv
`include "surf_defs.svh"

package surf_bus_pkg;

	// Window view of a word address.
	// The decoder looks at win, the slaves only see ofs.
	typedef struct packed {
		logic [`SURF_WIN_W-1:0] win;
		logic [`SURF_OFS_W-1:0] ofs;
	} wb_win_t;

	// Word address, read flat or split into window and offset.
	typedef union packed {
		logic [`SURF_ADR_W-1:0] flat;
		wb_win_t win_view;
	} wb_adr_t;

	// Master to slave side of the control bus.
	// Fields stay steady from stb until ack or err.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`SURF_SEL_W-1:0] sel;
		wb_adr_t adr;
		logic [`SURF_DATA_W-1:0] dat;
	} wb_req_t;

	// Slave to master side.
	// Read data is valid only alongside ack.
	typedef struct packed {
		logic ack;
		logic err;
		logic [`SURF_DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage

//--- logic/surf_defs.svh
`ifndef SURF_DEFS_SVH
`define SURF_DEFS_SVH

// Control bus geometry.
`define SURF_DATA_W 32
`define SURF_ADR_W 20
`define SURF_SEL_W 4
`define SURF_NUM_MASTERS 3

// Window number on top, word offset below it.
`define SURF_WIN_W 4
`define SURF_OFS_W 16

// Window map, 64K words each.
`define SURF_WIN_ID 4'd0
`define SURF_WIN_L4CTRL 4'd1
`define SURF_WIN_L4RAM 4'd2
`define SURF_WIN_RFP 4'd3

// Monitor timing inputs.
// Channel 11 has its differential pair swapped on the board.
`define SURF_MON_CH 12
`define SURF_MON_POL 12'h800

// Firmware version fields.
`define SURF_BOARDREV 4'd1
`define SURF_MONTH 4'd6
`define SURF_DAY 8'd27
`define SURF_MAJOR 4'd0
`define SURF_MINOR 4'd2
`define SURF_REVISION 8'd12

`endif
